//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ipod
FILELIST  ?= ipod_player.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/board_pkg.sv
package board_pkg;

  // Sample period in CLK_50M cycles
  typedef logic [15:0] period_t;

  // About 22 kHz at 50 MHz
  localparam int DEFAULT_PERIOD         = 2268;
  localparam int DEFAULT_STEP           = 100;
  // Ten speed events per second
  localparam int DEFAULT_REPEAT_CYCLES  = 5_000_000;
  // Display refresh at 2 Hz
  localparam int DEFAULT_REFRESH_CYCLES = 25_000_000;

  // Segments g..a, active low
  typedef logic [6:0] seg_t;

  localparam seg_t SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30,
    7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03,
    7'h46, 7'h21, 7'h06, 7'h0E
  };

  localparam seg_t SEG_BLANK = 7'h7F;

endpackage

//--- common/player_pkg.sv
package player_pkg;

  // ============================================================
  // Flash side of the datapath
  // ============================================================

  typedef logic [22:0] flash_addr_t;

  // Two samples per word, low half plays first going forward
  typedef logic [31:0] flash_word_t;

  typedef logic [15:0] sample_t;

  typedef struct packed {
    logic        read;
    flash_addr_t address;
  } flash_req_t;

  typedef struct packed {
    logic        waitrequest;
    logic        readdatavalid;
    flash_word_t readdata;
  } flash_rsp_t;

  typedef struct packed {
    logic playing;
    logic reverse;
  } play_ctrl_t;

  // ============================================================
  // Keyboard commands
  // ============================================================

  typedef logic [7:0] ascii_t;

  localparam ascii_t CMD_PLAY     = 8'h45;
  localparam ascii_t CMD_PAUSE    = 8'h44;
  localparam ascii_t CMD_FORWARD  = 8'h46;
  localparam ascii_t CMD_BACKWARD = 8'h42;
  localparam ascii_t CMD_RESTART  = 8'h52;

endpackage

//--- ipod_player.f
common/player_pkg.sv
common/board_pkg.sv
player/flash_reader.sv
player/sample_sequencer.sv
player/command_decoder.sv
logic/rate_control.sv
logic/hex_display.sv
logic/ipod_top.sv
sim/tb_ipod_properties.sv
sim/tb_ipod.sv

//--- logic/hex_display.sv
`timescale 1ns/1ps

module hex_display #(
  parameter int REFRESH_CYCLES = board_pkg::DEFAULT_REFRESH_CYCLES
) (
  input  logic                     CLK_50M,
  input  logic                     arst_n,
  input  board_pkg::period_t       period,
  output board_pkg::seg_t [5:0]    hex
);

  localparam int CW = $clog2(REFRESH_CYCLES + 1);

  logic [CW-1:0]      refresh_cnt;
  logic               refresh;
  board_pkg::period_t shown;

  assign refresh = (refresh_cnt == CW'(REFRESH_CYCLES - 1));

  // Period is sampled a few times a second so the digits stay readable
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      refresh_cnt <= '0;
      shown       <= '0;
    end
    else
    begin
      refresh_cnt <= refresh ? '0 : refresh_cnt + 1'b1;
      if (refresh)
        shown <= period;
    end
  end

  for (genvar i = 0; i < 6; i++)
  begin : g_digit
    if (i < 4)
    begin : g_nibble
      assign hex[i] = board_pkg::SEG_TABLE[shown[4*i +: 4]];
    end
    else
    begin : g_blank
      assign hex[i] = board_pkg::SEG_BLANK;
    end
  end

endmodule

//--- logic/ipod_top.sv
`timescale 1ns/1ps

module ipod_top #(
  parameter int SONG_WORDS     = 32'h40000,
  parameter int PERIOD_DEFAULT = board_pkg::DEFAULT_PERIOD,
  parameter int PERIOD_STEP    = board_pkg::DEFAULT_STEP,
  parameter int PERIOD_MIN     = board_pkg::DEFAULT_PERIOD / 2,
  parameter int PERIOD_MAX     = board_pkg::DEFAULT_PERIOD * 4,
  parameter int REPEAT_CYCLES  = board_pkg::DEFAULT_REPEAT_CYCLES,
  parameter int REFRESH_CYCLES = board_pkg::DEFAULT_REFRESH_CYCLES
) (
  input  logic                   CLK_50M,
  input  logic                   arst_n,
  input  logic [3:0]             key,
  input  player_pkg::ascii_t     kbd_ascii,
  input  logic                   kbd_strobe,
  input  player_pkg::flash_rsp_t flash_rsp,
  output player_pkg::flash_req_t flash_req,
  output player_pkg::sample_t    audio_sample,
  output logic                   sample_strobe,
  output board_pkg::seg_t [5:0]  hex
);

  // ============================================================
  // Interconnect
  // ============================================================

  logic                    fetch;
  player_pkg::flash_addr_t fetch_addr;
  player_pkg::flash_word_t word;
  logic                    done;
  player_pkg::play_ctrl_t  ctrl;
  logic                    restart;
  logic                    sample_tick;
  board_pkg::period_t      period;

  flash_reader u_flash_reader (
    .CLK_50M    (CLK_50M),
    .arst_n     (arst_n),
    .fetch      (fetch),
    .fetch_addr (fetch_addr),
    .flash_rsp  (flash_rsp),
    .flash_req  (flash_req),
    .word       (word),
    .done       (done)
  );

  sample_sequencer #(
    .SONG_WORDS (SONG_WORDS)
  ) u_sample_sequencer (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .sample_tick   (sample_tick),
    .ctrl          (ctrl),
    .restart       (restart),
    .word          (word),
    .done          (done),
    .fetch         (fetch),
    .fetch_addr    (fetch_addr),
    .audio_sample  (audio_sample),
    .sample_strobe (sample_strobe)
  );

  command_decoder u_command_decoder (
    .CLK_50M    (CLK_50M),
    .arst_n     (arst_n),
    .kbd_ascii  (kbd_ascii),
    .kbd_strobe (kbd_strobe),
    .ctrl       (ctrl),
    .restart    (restart)
  );

  // KEY[3] has no function on this board
  rate_control #(
    .PERIOD_DEFAULT (PERIOD_DEFAULT),
    .PERIOD_STEP    (PERIOD_STEP),
    .PERIOD_MIN     (PERIOD_MIN),
    .PERIOD_MAX     (PERIOD_MAX),
    .REPEAT_CYCLES  (REPEAT_CYCLES)
  ) u_rate_control (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .key         (key[2:0]),
    .period      (period),
    .sample_tick (sample_tick)
  );

  hex_display #(
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) u_hex_display (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .period  (period),
    .hex     (hex)
  );

endmodule

//--- logic/rate_control.sv
`timescale 1ns/1ps

module rate_control #(
  parameter int PERIOD_DEFAULT = board_pkg::DEFAULT_PERIOD,
  parameter int PERIOD_STEP    = board_pkg::DEFAULT_STEP,
  parameter int PERIOD_MIN     = board_pkg::DEFAULT_PERIOD / 2,
  parameter int PERIOD_MAX     = board_pkg::DEFAULT_PERIOD * 4,
  parameter int REPEAT_CYCLES  = board_pkg::DEFAULT_REPEAT_CYCLES
) (
  input  logic               CLK_50M,
  input  logic               arst_n,
  input  logic [2:0]         key,
  output board_pkg::period_t period,
  output logic               sample_tick
);

  localparam int RW = $clog2(REPEAT_CYCLES + 1);

  logic [2:0]         key_meta;
  logic [2:0]         key_sync;
  logic [RW-1:0]      rep_cnt;
  logic               rep_wrap;
  logic               slow_down;
  logic               speed_up;
  logic               speed_reset;
  board_pkg::period_t tick_cnt;

  // Keys are active low
  assign speed_up    = !key_sync[0];
  assign slow_down   = !key_sync[1];
  assign speed_reset = !key_sync[2];
  assign rep_wrap    = (rep_cnt == RW'(REPEAT_CYCLES - 1));

  // ============================================================
  // Key synchronizer and repeat limiter
  // ============================================================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      key_meta <= '1;
      key_sync <= '1;
      rep_cnt  <= '0;
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
      rep_cnt  <= rep_wrap ? '0 : rep_cnt + 1'b1;
    end
  end

  // ============================================================
  // Clamped period and sample tick
  // ============================================================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      period      <= board_pkg::period_t'(PERIOD_DEFAULT);
      tick_cnt    <= '0;
      sample_tick <= 1'b0;
    end
    else
    begin
      if (speed_reset)
        period <= board_pkg::period_t'(PERIOD_DEFAULT);
      else if (rep_wrap && speed_up && !slow_down)
        period <= (period < PERIOD_MIN + PERIOD_STEP) ?
                  board_pkg::period_t'(PERIOD_MIN) : period - PERIOD_STEP[15:0];
      else if (rep_wrap && slow_down && !speed_up)
        period <= (period > PERIOD_MAX - PERIOD_STEP) ?
                  board_pkg::period_t'(PERIOD_MAX) : period + PERIOD_STEP[15:0];

      // Greater-or-equal also covers a period that just shrank
      if (tick_cnt + 1'b1 >= period)
      begin
        tick_cnt    <= '0;
        sample_tick <= 1'b1;
      end
      else
      begin
        tick_cnt    <= tick_cnt + 1'b1;
        sample_tick <= 1'b0;
      end
    end
  end

endmodule

//--- player/command_decoder.sv
`timescale 1ns/1ps

module command_decoder (
  input  logic                   CLK_50M,
  input  logic                   arst_n,
  input  player_pkg::ascii_t     kbd_ascii,
  input  logic                   kbd_strobe,
  output player_pkg::play_ctrl_t ctrl,
  output logic                   restart
);

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ctrl    <= '0;
      restart <= 1'b0;
    end
    else
    begin
      restart <= 1'b0;
      if (kbd_strobe)
      begin
        case (kbd_ascii)
          player_pkg::CMD_PLAY:     ctrl.playing <= 1'b1;
          player_pkg::CMD_PAUSE:    ctrl.playing <= 1'b0;
          player_pkg::CMD_FORWARD:  ctrl.reverse <= 1'b0;
          player_pkg::CMD_BACKWARD: ctrl.reverse <= 1'b1;
          // Single pulse to the sequencer
          player_pkg::CMD_RESTART:  restart <= 1'b1;
          default:
          begin
            // Unknown keys are ignored
          end
        endcase
      end
    end
  end

endmodule

//--- player/flash_reader.sv
`timescale 1ns/1ps

module flash_reader (
  input  logic                    CLK_50M,
  input  logic                    arst_n,
  input  logic                    fetch,
  input  player_pkg::flash_addr_t fetch_addr,
  input  player_pkg::flash_rsp_t  flash_rsp,
  output player_pkg::flash_req_t  flash_req,
  output player_pkg::flash_word_t word,
  output logic                    done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT
  } state_t;

  state_t                  state;
  player_pkg::flash_addr_t addr_q;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= ST_IDLE;
      done  <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (fetch)
            state <= ST_REQ;
        end
        ST_REQ:
        begin
          // Held until the slave drops waitrequest
          if (!flash_rsp.waitrequest)
            state <= ST_WAIT;
        end
        ST_WAIT:
        begin
          if (flash_rsp.readdatavalid)
          begin
            state <= ST_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (state == ST_IDLE && fetch)
      addr_q <= fetch_addr;
    if (state == ST_WAIT && flash_rsp.readdatavalid)
      word <= flash_rsp.readdata;
  end

  assign flash_req.read    = (state == ST_REQ);
  assign flash_req.address = addr_q;

endmodule

//--- player/sample_sequencer.sv
`timescale 1ns/1ps

module sample_sequencer #(
  parameter int SONG_WORDS = 32'h40000
) (
  input  logic                    CLK_50M,
  input  logic                    arst_n,
  input  logic                    sample_tick,
  input  player_pkg::play_ctrl_t  ctrl,
  input  logic                    restart,
  input  player_pkg::flash_word_t word,
  input  logic                    done,
  output logic                    fetch,
  output player_pkg::flash_addr_t fetch_addr,
  output player_pkg::sample_t     audio_sample,
  output logic                    sample_strobe
);

  localparam player_pkg::flash_addr_t LAST_ADDR = player_pkg::flash_addr_t'(SONG_WORDS - 1);

  player_pkg::flash_addr_t addr;
  player_pkg::flash_addr_t next_addr;
  // Low means the next tick starts a new word
  logic                    half;
  logic                    pending;
  // Read in flight that a restart has made stale
  logic                    discard;
  logic                    rev_word;

  logic tick_ok;
  logic start_fetch;
  logic take_first;
  logic take_second;

  // The cycle that shows the first sample still counts as busy
  assign tick_ok     = sample_tick && ctrl.playing && !pending && !sample_strobe;
  assign start_fetch = tick_ok && !half && !restart;
  assign take_second = tick_ok && half && !restart;
  assign take_first  = done && !discard && !restart;

  always_comb
  begin
    if (rev_word)
      next_addr = (addr == '0) ? LAST_ADDR : addr - 1'b1;
    else
      next_addr = (addr == LAST_ADDR) ? '0 : addr + 1'b1;
  end

  // ============================================================
  // Word address, half select and fetch tracking
  // ============================================================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      addr          <= '0;
      half          <= 1'b0;
      pending       <= 1'b0;
      discard       <= 1'b0;
      rev_word      <= 1'b0;
      fetch         <= 1'b0;
      sample_strobe <= 1'b0;
    end
    else
    begin
      fetch         <= start_fetch;
      sample_strobe <= take_first || take_second;

      if (start_fetch)
      begin
        pending  <= 1'b1;
        rev_word <= ctrl.reverse;
      end
      else if (done)
        pending <= 1'b0;

      if (done)
        discard <= 1'b0;
      else if (restart && pending)
        discard <= 1'b1;

      if (restart)
      begin
        addr <= ctrl.reverse ? LAST_ADDR : '0;
        half <= 1'b0;
      end
      else if (take_first)
        half <= 1'b1;
      else if (take_second)
      begin
        half <= 1'b0;
        addr <= next_addr;
      end
    end
  end

  // Direction of the word decides which half goes first
  always_ff @(posedge CLK_50M)
  begin
    if (take_first)
      audio_sample <= rev_word ? word[31:16] : word[15:0];
    else if (take_second)
      audio_sample <= rev_word ? word[15:0] : word[31:16];
  end

  assign fetch_addr = addr;

endmodule

//--- sim/tb_ipod.sv
`timescale 1ns/1ps

module tb_ipod;

  localparam int SONG_WORDS     = 8;
  localparam int PERIOD_DEFAULT = 60;
  localparam int PERIOD_STEP    = 8;
  localparam int PERIOD_MIN     = 36;
  localparam int PERIOD_MAX     = 84;
  localparam int REPEAT_CYCLES  = 40;
  localparam int REFRESH_CYCLES = 16;
  // Rough length of all tests in sample periods
  localparam int TEST_PERIODS   = 300;

  // Hex glyphs with segments g..a active low
  localparam logic [6:0] GLYPH [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic                   CLK_50M = 1'b0;
  logic                   arst_n;
  logic [3:0]             key;
  player_pkg::ascii_t     kbd_ascii;
  logic                   kbd_strobe;
  player_pkg::flash_rsp_t flash_rsp;
  player_pkg::flash_req_t flash_req;
  player_pkg::sample_t    audio_sample;
  logic                   sample_strobe;
  board_pkg::seg_t [5:0]  hex;

  int          errors = 0;
  int          checks = 0;
  int          strobe_count = 0;
  logic [15:0] lfsr = 16'd56138;
  logic        stall_en = 1'b0;
  logic [2:0]  ws_left = '0;
  logic [2:0]  lat_left = '0;
  logic [22:0] fm_addr = '0;

  // Reference model of the sample order
  logic [2:0]  exp_addr = '0;
  logic        exp_first = 1'b1;
  logic        word_rev = 1'b0;
  logic        tb_rev = 1'b0;

  ipod_top #(
    .SONG_WORDS     (SONG_WORDS),
    .PERIOD_DEFAULT (PERIOD_DEFAULT),
    .PERIOD_STEP    (PERIOD_STEP),
    .PERIOD_MIN     (PERIOD_MIN),
    .PERIOD_MAX     (PERIOD_MAX),
    .REPEAT_CYCLES  (REPEAT_CYCLES),
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) UUT (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .key           (key),
    .kbd_ascii     (kbd_ascii),
    .kbd_strobe    (kbd_strobe),
    .flash_rsp     (flash_rsp),
    .flash_req     (flash_req),
    .audio_sample  (audio_sample),
    .sample_strobe (sample_strobe),
    .hex           (hex)
  );

  always #10 CLK_50M = ~CLK_50M;

  // Galois LFSR stepped once per bit taken
  function automatic logic [2:0] draw_bits(int n);
    logic [2:0] r;
    logic       b;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b)
        lfsr = lfsr ^ 16'hB400;
      r = {r[1:0], b};
    end
    return r;
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("FAIL at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  // ============================================================
  // Flash model
  // ============================================================

  always @(posedge CLK_50M)
  begin
    logic [2:0] ws;
    logic [2:0] lat;
    flash_rsp.readdatavalid <= 1'b0;
    if (lat_left != 0)
    begin
      lat_left <= lat_left - 1'b1;
      if (lat_left == 3'd1)
      begin
        flash_rsp.readdatavalid <= 1'b1;
        flash_rsp.readdata <= {16'hA000 + fm_addr[15:0], 16'h5000 + fm_addr[15:0]};
      end
    end
    else if (flash_req.read && !flash_rsp.waitrequest)
    begin
      ws  = stall_en ? draw_bits(2) : 3'd0;
      lat = stall_en ? draw_bits(2) + 3'd1 : 3'd1;
      fm_addr  <= flash_req.address;
      lat_left <= lat;
      // Wait states of the next read
      flash_rsp.waitrequest <= (ws != 0);
      ws_left  <= (ws != 0) ? ws - 1'b1 : 3'd0;
    end
    else if (flash_req.read && flash_rsp.waitrequest)
    begin
      if (ws_left == 0)
        flash_rsp.waitrequest <= 1'b0;
      else
        ws_left <= ws_left - 1'b1;
    end
  end

  // Every strobe is compared with the next sample of the song
  always @(posedge CLK_50M)
  begin
    logic [15:0] expected;
    if (arst_n && sample_strobe)
    begin
      strobe_count++;
      if (exp_first)
      begin
        word_rev = tb_rev;
        expected = word_rev ? 16'hA000 + exp_addr : 16'h5000 + exp_addr;
        exp_first = 1'b0;
      end
      else
      begin
        expected = word_rev ? 16'h5000 + exp_addr : 16'hA000 + exp_addr;
        exp_addr = word_rev ? exp_addr - 1'b1 : exp_addr + 1'b1;
        exp_first = 1'b1;
      end
      check_value("audio_sample", expected, audio_sample);
    end
  end

  // ============================================================
  // Stimulus helpers
  // ============================================================

  task automatic send_cmd(player_pkg::ascii_t code);
    @(posedge CLK_50M);
    kbd_ascii  <= code;
    kbd_strobe <= 1'b1;
    @(posedge CLK_50M);
    kbd_strobe <= 1'b0;
    if (code == player_pkg::CMD_BACKWARD)
      tb_rev = 1'b1;
    if (code == player_pkg::CMD_FORWARD)
      tb_rev = 1'b0;
  endtask

  task automatic wait_strobes(int n);
    int target;
    int cycles;
    target = strobe_count + n;
    cycles = 0;
    while (strobe_count < target && cycles < n * (2 * PERIOD_MAX + 20))
    begin
      @(posedge CLK_50M);
      cycles++;
    end
    if (strobe_count < target)
    begin
      errors++;
      $display("Timed out waiting for %0d sample strobes at %0t", n, $time);
    end
  endtask

  // Pause and let any read in flight finish
  task automatic pause_quiet();
    send_cmd(player_pkg::CMD_PAUSE);
    repeat (20) @(posedge CLK_50M);
  endtask

  task automatic restart_song();
    send_cmd(player_pkg::CMD_RESTART);
    repeat (2) @(posedge CLK_50M);
    exp_addr  = tb_rev ? 3'(SONG_WORDS - 1) : 3'd0;
    exp_first = 1'b1;
  endtask

  task automatic check_display(int expected);
    for (int i = 0; i < 4; i++)
      check_value($sformatf("hex[%0d]", i), GLYPH[(expected >> (4 * i)) & 15], hex[i]);
    check_value("hex[4]", 7'h7F, hex[4]);
    check_value("hex[5]", 7'h7F, hex[5]);
  endtask

  task automatic hold_key(int idx, int cycles, int expected);
    @(posedge CLK_50M);
    key[idx] <= 1'b0;
    repeat (cycles) @(posedge CLK_50M);
    key[idx] <= 1'b1;
    repeat (2 * REFRESH_CYCLES + 4) @(posedge CLK_50M);
    check_display(expected);
  endtask

  // ============================================================
  // Directed tests
  // ============================================================

  task automatic test_reset();
    check_value("flash_req.read", 1'b0, flash_req.read);
    check_value("sample_strobe", 1'b0, sample_strobe);
    repeat (4 * PERIOD_DEFAULT) @(posedge CLK_50M);
    check_value("strobe_count", 0, strobe_count);
    check_display(PERIOD_DEFAULT);
  endtask

  task automatic test_forward();
    send_cmd(player_pkg::CMD_PLAY);
    wait_strobes(2 * SONG_WORDS + 4);
  endtask

  task automatic test_pause();
    int seen;
    pause_quiet();
    seen = strobe_count;
    repeat (4 * PERIOD_DEFAULT) @(posedge CLK_50M);
    check_value("strobe_count", seen, strobe_count);
    send_cmd(player_pkg::CMD_PLAY);
    wait_strobes(6);
  endtask

  task automatic test_backward();
    pause_quiet();
    send_cmd(player_pkg::CMD_BACKWARD);
    send_cmd(player_pkg::CMD_PLAY);
    wait_strobes(2 * SONG_WORDS + 4);
    pause_quiet();
    restart_song();
    send_cmd(player_pkg::CMD_PLAY);
    wait_strobes(4);
    pause_quiet();
    send_cmd(player_pkg::CMD_FORWARD);
    restart_song();
    send_cmd(player_pkg::CMD_PLAY);
    wait_strobes(4);
  endtask

  task automatic test_speed();
    hold_key(0, REPEAT_CYCLES, PERIOD_DEFAULT - PERIOD_STEP);
    hold_key(0, 8 * REPEAT_CYCLES, PERIOD_MIN);
    hold_key(1, REPEAT_CYCLES, PERIOD_MIN + PERIOD_STEP);
    hold_key(1, 10 * REPEAT_CYCLES, PERIOD_MAX);
    hold_key(2, 10, PERIOD_DEFAULT);
  endtask

  task automatic test_stalls();
    stall_en <= 1'b1;
    wait_strobes(2 * SONG_WORDS + 4);
    stall_en <= 1'b0;
  endtask

  initial
  begin
    #(longint'(TEST_PERIODS) * PERIOD_MAX * 20 * 2);
    $display("Watchdog expired before the tests finished");
    $display("TEST FAIL");
    $finish;
  end

  initial
  begin
    arst_n     = 1'b0;
    key        = 4'hF;
    kbd_ascii  = '0;
    kbd_strobe = 1'b0;
    flash_rsp  = '0;
    repeat (4) @(posedge CLK_50M);
    arst_n <= 1'b1;
    @(posedge CLK_50M);
    test_reset();
    test_forward();
    test_pause();
    test_backward();
    test_speed();
    test_stalls();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- sim/tb_ipod_properties.sv
`timescale 1ns/1ps

module tb_ipod_properties (
  input logic                    CLK_50M,
  input logic                    arst_n,
  input logic                    read,
  input player_pkg::flash_addr_t address,
  input logic                    waitrequest,
  input logic                    readdatavalid,
  input logic                    strobe
);

  // Read accepted and data not yet back
  logic outstanding;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      outstanding <= 1'b0;
    else if (read && !waitrequest)
      outstanding <= 1'b1;
    else if (readdatavalid)
      outstanding <= 1'b0;
  end

  a_req_stable : assert property (@(posedge CLK_50M) disable iff (!arst_n)
    read && waitrequest |=> read && $stable(address))
    else $error("flash read or address changed while waitrequest was high");

  a_one_read : assert property (@(posedge CLK_50M) disable iff (!arst_n)
    outstanding |-> !read)
    else $error("new flash read started before readdatavalid");

  a_strobe_single : assert property (@(posedge CLK_50M) disable iff (!arst_n)
    strobe |=> !strobe)
    else $error("sample_strobe high on two cycles in a row");

endmodule

bind flash_reader tb_ipod_properties u_flash_props (
  .CLK_50M       (CLK_50M),
  .arst_n        (arst_n),
  .read          (flash_req.read),
  .address       (flash_req.address),
  .waitrequest   (flash_rsp.waitrequest),
  .readdatavalid (flash_rsp.readdatavalid),
  .strobe        (1'b0)
);

bind sample_sequencer tb_ipod_properties u_seq_props (
  .CLK_50M       (CLK_50M),
  .arst_n        (arst_n),
  .read          (1'b0),
  .address       ('0),
  .waitrequest   (1'b0),
  .readdatavalid (1'b0),
  .strobe        (sample_strobe)
);
